/* logic/cmbPkg.sv */
package cmbPkg;

    // ------------------------------------------------
    // Flash address layout
    // ------------------------------------------------
    localparam int lpBlockBits = 10;                            // Block field
    localparam int lpPageBits  = 6;                             // Page field
    localparam int lpColBits   = 11;                            // Column field
    localparam int lpAddrBits  = lpBlockBits + lpPageBits + lpColBits;  // 27 bits total

    // One page step, column field rolls into page
    localparam logic [lpAddrBits-1:0] lpPageUp = lpAddrBits'(1) << lpColBits;

    localparam int lpSectorBytes = 16;                          // Bytes per flash read
    localparam logic lpCmdRead   = 1'b1;                        // Flash command, read only

    // ------------------------------------------------
    // Sound path sizes
    // ------------------------------------------------
    localparam int lpSampleBits   = 16;                         // One sound sample
    localparam int lpChannels     = 5;                          // Sound generator channels
    localparam int lpChanBits     = $clog2(lpChannels);         // Channel pointer
    localparam int lpSoundCredits = 2;                          // Credits per channel
    localparam int lpCreditBits   = $clog2(lpSoundCredits + 1); // Credit counter
    localparam int lpQueueDepth   = lpSectorBytes / 2;          // One sector of samples
    localparam int lpQueuePtrBits = $clog2(lpQueueDepth);       // Queue pointer
    localparam int lpQueueCntBits = $clog2(lpQueueDepth + 1);   // Queue fill level

    // ------------------------------------------------
    // Slave CSR bus
    // ------------------------------------------------
    localparam int lpSlaveBits = 16;                            // Slave addr and data width
    localparam logic [lpSlaveBits-1:0] lpEndAddr = 16'hFFFF;    // End-of-program marker

    // Per-port request FSM states
    localparam logic [1:0] lpStIdle = 2'd0;                     // Nothing pending
    localparam logic [1:0] lpStReq  = 2'd1;                     // Cke cycle
    localparam logic [1:0] lpStBusy = 2'd2;                     // Sector in flight

    typedef struct packed {
        logic [lpAddrBits-1:0] addr;                            // Block, page, column
        logic                  cke;                             // One-cycle read start
        logic                  cmd;                             // 1 read
    } fmcReq_t;

    typedef struct packed {
        logic [7:0] rd;                                         // Data byte
        logic       rdVd;                                       // Byte valid
        logic       sectorCke;                                  // Sector done pulse
    } fmcRsp_t;

    typedef struct packed {
        logic [lpSlaveBits-1:0] addr;                           // CSR address
        logic [lpSlaveBits-1:0] wd;                             // CSR write data
        logic                   wdVd;                           // Write strobe
    } slaveWr_t;

    typedef struct packed {
        logic [lpSampleBits-1:0] sample;                        // Sample value
        logic                    vd;                            // Valid strobe
    } sgbSample_t;

endpackage

/* logic/cmbControl.sv */
module cmbControl (
    input  logic            iSysClk,        // System clock
    input  logic            reset,          // Sync reset, active high
    input  cmbPkg::fmcRsp_t pixelRsp,       // Pixel flash response
    input  cmbPkg::fmcRsp_t soundRsp,       // Sound flash response
    input  logic            programEnd,     // End instruction decoded
    input  logic            queueEmpty,     // Sound queue drained
    output cmbPkg::fmcReq_t pixelReq,       // Pixel flash request
    output cmbPkg::fmcReq_t soundReq        // Sound flash request
);
    import cmbPkg::*;

    logic [1:0]            pixState;        // Pixel port FSM
    logic [1:0]            soundState;      // Sound port FSM
    logic [lpAddrBits-1:0] pixAddr;         // Pixel page address
    logic [lpAddrBits-1:0] soundAddr;       // Sound page address
    logic                  programEnded;    // Sticky end flag
    logic                  endSeen;         // End flag incl. this cycle

    assign endSeen = programEnded | programEnd;

    always_ff @(posedge iSysClk)
    begin
        if (reset)
            programEnded <= 1'b0;
        else if (programEnd)
            programEnded <= 1'b1;           // Held until reset
    end

    // ------------------------------------------------
    // Pixel port, one sector after another until end
    // ------------------------------------------------
    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            pixState <= lpStIdle;
            pixAddr  <= '0;
        end
        else
        begin
            case (pixState)
                lpStIdle:
                begin
                    if (!endSeen)
                        pixState <= lpStReq;                // Start right after reset
                end
                lpStReq:
                    pixState <= lpStBusy;                   // Cke is out this cycle
                lpStBusy:
                begin
                    if (pixelRsp.sectorCke)
                    begin
                        pixAddr  <= pixAddr + lpPageUp;     // Next page
                        pixState <= endSeen ? lpStIdle : lpStReq;
                    end
                end
                default:
                    pixState <= lpStIdle;
            endcase
        end
    end

    // ------------------------------------------------
    // Sound port, refill only when the queue drains
    // ------------------------------------------------
    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            soundState <= lpStIdle;
            soundAddr  <= '0;
        end
        else
        begin
            case (soundState)
                lpStIdle:
                begin
                    if (queueEmpty)
                        soundState <= lpStReq;
                end
                lpStReq:
                    soundState <= lpStBusy;
                lpStBusy:
                begin
                    if (soundRsp.sectorCke)
                    begin
                        soundAddr  <= soundAddr + lpPageUp;
                        soundState <= lpStIdle;             // Wait for queue to drain
                    end
                end
                default:
                    soundState <= lpStIdle;
            endcase
        end
    end

    always_comb
    begin
        pixelReq.addr = pixAddr;
        pixelReq.cke  = (pixState == lpStReq);
        pixelReq.cmd  = lpCmdRead;
        soundReq.addr = soundAddr;
        soundReq.cke  = (soundState == lpStReq);
        soundReq.cmd  = lpCmdRead;
    end

    // Flash traffic only inside an accepted sector, so no overlapping cke
    assert property (@(posedge iSysClk) disable iff (reset)
        (pixelRsp.rdVd || pixelRsp.sectorCke) |-> pixState == lpStBusy)
        else $error("pixel flash active outside a sector");

    assert property (@(posedge iSysClk) disable iff (reset)
        (soundRsp.rdVd || soundRsp.sectorCke) |-> soundState == lpStBusy)
        else $error("sound flash active outside a sector");

endmodule

/* logic/pixelCmdDecoder.sv */
module pixelCmdDecoder (
    input  logic             iSysClk,       // System clock
    input  logic             reset,         // Sync reset, active high
    input  cmbPkg::fmcRsp_t  pixelRsp,      // Pixel flash bytes
    output cmbPkg::slaveWr_t slaveWr,       // CSR write to slaves
    output logic             programEnd     // End instruction pulse
);
    import cmbPkg::*;

    logic [1:0]                 byteCnt;    // Byte slot in instruction
    logic [4*8-1:0]             instr;      // Addr hi, addr lo, data hi, data lo
    logic [4*8-1:0]             instrNext;  // Instruction with current byte
    logic [lpSlaveBits-1:0]     nextAddr;   // Address field of instrNext
    logic                       takeByte;   // Byte accepted
    logic                       lastByte;   // Fourth byte accepted
    logic                       wdVd;       // Write strobe register
    logic                       ended;      // Program finished

    // Bytes after the end marker are dropped
    assign takeByte  = pixelRsp.rdVd && !ended;
    assign lastByte  = takeByte && (byteCnt == 2'd3);
    assign instrNext = {instr[3*8-1:0], pixelRsp.rd};
    assign nextAddr  = instrNext[4*8-1:2*8];

    always_ff @(posedge iSysClk)
    begin
        if (takeByte)
            instr <= instrNext;             // High byte first
    end

    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            byteCnt    <= 2'd0;
            wdVd       <= 1'b0;
            programEnd <= 1'b0;
            ended      <= 1'b0;
        end
        else
        begin
            wdVd       <= lastByte && (nextAddr != lpEndAddr);
            programEnd <= lastByte && (nextAddr == lpEndAddr);
            if (takeByte)
                byteCnt <= byteCnt + 2'd1;  // Wraps on fourth byte
            if (lastByte && (nextAddr == lpEndAddr))
                ended <= 1'b1;
        end
    end

    always_comb
    begin
        slaveWr.addr = instr[4*8-1:2*8];
        slaveWr.wd   = instr[2*8-1:0];
        slaveWr.wdVd = wdVd;
    end

    // Sectors carry whole instructions
    assert property (@(posedge iSysClk) disable iff (reset)
        pixelRsp.sectorCke |-> byteCnt == 2'd0)
        else $error("pixel sector ended inside an instruction");

endmodule

/* logic/soundSampleQueue.sv */
module soundSampleQueue (
    input  logic                            iSysClk,    // System clock
    input  logic                            reset,      // Sync reset, active high
    input  cmbPkg::fmcRsp_t                 soundRsp,   // Sound flash bytes
    input  logic                            pop,        // Dispatcher takes head
    output logic [cmbPkg::lpSampleBits-1:0] head,       // Oldest sample
    output logic                            notEmpty,   // Head is valid
    output logic                            queueEmpty  // Nothing buffered
);
    import cmbPkg::*;

    logic [7:0]                 hiByte;     // First byte of a sample
    logic                       phase;      // 1 after high byte
    logic                       push;       // Second byte completes a sample
    logic [lpSampleBits-1:0]    mem [lpQueueDepth];
    logic [lpQueuePtrBits-1:0]  wrPtr;
    logic [lpQueuePtrBits-1:0]  rdPtr;
    logic [lpQueueCntBits-1:0]  count;      // Fill level

    assign push = soundRsp.rdVd && phase;

    // ------------------------------------------------
    // Byte pairing and storage
    // ------------------------------------------------
    always_ff @(posedge iSysClk)
    begin
        if (soundRsp.rdVd && !phase)
            hiByte <= soundRsp.rd;                  // Hold high byte
        if (push)
            mem[wrPtr] <= {hiByte, soundRsp.rd};    // Sample lands here
    end

    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            phase <= 1'b0;
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end
        else
        begin
            if (soundRsp.rdVd)
                phase <= !phase;
            if (push)
                wrPtr <= (wrPtr == lpQueuePtrBits'(lpQueueDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (pop)
                rdPtr <= (rdPtr == lpQueuePtrBits'(lpQueueDepth - 1)) ? '0 : rdPtr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // Both or neither
            endcase
        end
    end

    assign head       = mem[rdPtr];
    assign notEmpty   = (count != '0);
    assign queueEmpty = (count == '0);

    assert property (@(posedge iSysClk) disable iff (reset)
        push |-> count != lpQueueCntBits'(lpQueueDepth))
        else $error("sample pushed into a full queue");

    assert property (@(posedge iSysClk) disable iff (reset)
        pop |-> count != '0)
        else $error("pop from an empty queue");

    // Sector boundaries fall between samples
    assert property (@(posedge iSysClk) disable iff (reset)
        soundRsp.sectorCke |-> !phase)
        else $error("sound sector ended on a half sample");

endmodule

/* logic/sgbDispatcher.sv */
module sgbDispatcher (
    input  logic                                          iSysClk,    // System clock
    input  logic                                          reset,      // Sync reset
    input  logic [cmbPkg::lpSampleBits-1:0]               head,       // Queue head
    input  logic                                          notEmpty,   // Head valid
    input  logic [cmbPkg::lpChannels-1:0]                 iSgbCredit, // Credit return
    output logic                                          pop,        // Take head
    output cmbPkg::sgbSample_t [cmbPkg::lpChannels-1:0]   sgbOut      // Channel outputs
);
    import cmbPkg::*;

    logic [lpChanBits-1:0]      chanPtr;                // Channel served next
    logic [lpCreditBits-1:0]    credit [lpChannels];    // Credits left per channel
    logic [lpSampleBits-1:0]    sampleReg [lpChannels]; // Last sample per channel
    logic [lpChannels-1:0]      vdReg;                  // Valid strobes
    logic [lpChannels-1:0]      hasCredit;              // Credit above zero
    logic [lpChannels-1:0]      sendMask;               // One-hot send
    logic                       send;

    always_comb
    begin
        for (int i = 0; i < lpChannels; i++)
        begin
            hasCredit[i] = (credit[i] != '0);
            sendMask[i]  = send && (chanPtr == lpChanBits'(i));
        end
    end

    // Stall on a channel without credit, never skip it
    assign send = notEmpty && hasCredit[chanPtr];
    assign pop  = send;

    always_ff @(posedge iSysClk)
    begin
        for (int i = 0; i < lpChannels; i++)
        begin
            if (sendMask[i])
                sampleReg[i] <= head;   // Out one cycle after pop
        end
    end

    always_ff @(posedge iSysClk)
    begin
        if (reset)
        begin
            chanPtr <= '0;
            vdReg   <= '0;
            for (int i = 0; i < lpChannels; i++)
                credit[i] <= lpCreditBits'(lpSoundCredits);
        end
        else
        begin
            vdReg <= sendMask;
            if (send)
                chanPtr <= (chanPtr == lpChanBits'(lpChannels - 1)) ? '0 : chanPtr + 1'b1;
            for (int i = 0; i < lpChannels; i++)
            begin
                case ({iSgbCredit[i], sendMask[i]})
                    2'b10:   credit[i] <= credit[i] + 1'b1;  // Credit back
                    2'b01:   credit[i] <= credit[i] - 1'b1;  // Credit spent
                    default: credit[i] <= credit[i];         // Cancel or idle
                endcase
            end
        end
    end

    always_comb
    begin
        for (int i = 0; i < lpChannels; i++)
        begin
            sgbOut[i].sample = sampleReg[i];
            sgbOut[i].vd     = vdReg[i];
        end
    end

    // Sound generator returns only credits it was given, so no counter overflows
    for (genvar g = 0; g < lpChannels; g++)
    begin : gCreditCheck
        assert property (@(posedge iSysClk) disable iff (reset)
            (iSgbCredit[g] && !sendMask[g]) |-> credit[g] < lpCreditBits'(lpSoundCredits))
            else $error("credit counter of channel %0d above limit", g);
    end

endmodule

/* logic/cmbWrapper.sv */
module cmbWrapper (
    input  logic                                        iSysClk,    // System clock
    input  logic                                        reset,      // Sync reset
    input  cmbPkg::fmcRsp_t                             pixelRsp,   // Pixel flash in
    input  cmbPkg::fmcRsp_t                             soundRsp,   // Sound flash in
    input  logic [cmbPkg::lpChannels-1:0]               iSgbCredit, // Credit return
    output cmbPkg::fmcReq_t                             pixelReq,   // Pixel flash out
    output cmbPkg::fmcReq_t                             soundReq,   // Sound flash out
    output cmbPkg::slaveWr_t                            slaveWr,    // Slave CSR write
    output cmbPkg::sgbSample_t [cmbPkg::lpChannels-1:0] sgbOut      // Sound channels
);
    import cmbPkg::*;

    logic                    programEnd;    // Decoder to control
    logic                    queueEmpty;    // Queue to control
    logic [lpSampleBits-1:0] head;          // Queue to dispatcher
    logic                    notEmpty;
    logic                    pop;           // Dispatcher to queue

    cmbControl cmbControl_inst (
        .iSysClk    (iSysClk),
        .reset      (reset),
        .pixelRsp   (pixelRsp),
        .soundRsp   (soundRsp),
        .programEnd (programEnd),
        .queueEmpty (queueEmpty),
        .pixelReq   (pixelReq),
        .soundReq   (soundReq)
    );

    // Pixel path, system program to slave bus
    pixelCmdDecoder pixelCmdDecoder_inst (
        .iSysClk    (iSysClk),
        .reset      (reset),
        .pixelRsp   (pixelRsp),
        .slaveWr    (slaveWr),
        .programEnd (programEnd)
    );

    // Sound path, bytes to samples to channels
    soundSampleQueue soundSampleQueue_inst (
        .iSysClk    (iSysClk),
        .reset      (reset),
        .soundRsp   (soundRsp),
        .pop        (pop),
        .head       (head),
        .notEmpty   (notEmpty),
        .queueEmpty (queueEmpty)
    );

    sgbDispatcher sgbDispatcher_inst (
        .iSysClk    (iSysClk),
        .reset      (reset),
        .head       (head),
        .notEmpty   (notEmpty),
        .iSgbCredit (iSgbCredit),
        .pop        (pop),
        .sgbOut     (sgbOut)
    );

endmodule

/* bench/cmbWrapperTb.sv */
module cmbWrapperTb;
    timeunit 1ns;
    timeprecision 100ps;

    import cmbPkg::*;

    localparam int lpImageBytes    = 64 * lpSectorBytes;    // One sector per page value
    localparam int lpProgInstr     = 5;                     // Writes before the end marker
    localparam int lpRouteSamples  = 40;                    // Samples in the routing test
    localparam int lpTimeoutCycles = 4000;                  // About ten sectors plus stall waits

    // Program image, address in the upper half
    localparam logic [31:0] lpProgram [lpProgInstr+1] = '{
        32'h0010_1234, 32'h0024_BEEF, 32'h0100_00FF,
        32'h7F02_A55A, 32'hFFFE_0001, 32'hFFFF_0000
    };

    logic                           iSysClk;
    logic                           reset;
    fmcRsp_t                        pixelRsp;
    fmcRsp_t                        soundRsp;
    logic [lpChannels-1:0]          iSgbCredit;
    fmcReq_t                        pixelReq;
    fmcReq_t                        soundReq;
    slaveWr_t                       slaveWr;
    sgbSample_t [lpChannels-1:0]    sgbOut;

    logic [7:0]             pixImage [lpImageBytes];    // Pixel flash contents
    logic [7:0]             soundImage [lpImageBytes];  // Sound flash contents
    integer                 seed;
    int                     errCount;
    int                     checkCount;
    int                     cycleCount;
    int                     pixSectorsDone;             // Completed pixel sectors
    int                     pixBase;
    int                     soundBase;
    int                     owed [lpChannels];          // Credits held by the DUT side
    int                     manualReq [lpChannels];     // Single credit returns asked for
    int                     manualDone [lpChannels];
    logic                   autoCredit;                 // Return credits right away
    logic [lpAddrBits-1:0]  pixAddrQ [$];               // Addresses seen with cke
    logic [lpAddrBits-1:0]  soundAddrQ [$];
    logic [31:0]            slaveQ [$];                 // {addr, wd} per write
    int                     chanQ [$];                  // Channel of each sample
    logic [lpSampleBits-1:0] valQ [$];

    cmbWrapper cmbWrapper_inst (
        .iSysClk    (iSysClk),
        .reset      (reset),
        .pixelRsp   (pixelRsp),
        .soundRsp   (soundRsp),
        .iSgbCredit (iSgbCredit),
        .pixelReq   (pixelReq),
        .soundReq   (soundReq),
        .slaveWr    (slaveWr),
        .sgbOut     (sgbOut)
    );

    initial
    begin
        iSysClk = 1'b0;
        forever #4 iSysClk = ~iSysClk;                  // 8 ns period
    end

    // ------------------------------------------------
    // Flash models, one sector per cke
    // ------------------------------------------------
    initial
    begin
        pixelRsp       = '0;
        pixSectorsDone = 0;
        forever
        begin
            @(negedge iSysClk);
            pixelRsp.sectorCke = 1'b0;
            if (pixelReq.cke === 1'b1)
            begin
                pixBase = int'(pixelReq.addr[lpColBits +: lpPageBits]) * lpSectorBytes;
                for (int j = 0; j < lpSectorBytes; j++)
                begin
                    @(negedge iSysClk);
                    pixelRsp.rd   = pixImage[pixBase + j];
                    pixelRsp.rdVd = 1'b1;
                    if (j % 5 == 4)
                    begin
                        @(negedge iSysClk);
                        pixelRsp.rdVd = 1'b0;   // Idle gap
                    end
                end
                @(negedge iSysClk);
                pixelRsp.rdVd      = 1'b0;
                pixelRsp.sectorCke = 1'b1;      // Cleared on the next loop pass
                pixSectorsDone++;
            end
        end
    end

    initial
    begin
        soundRsp = '0;
        forever
        begin
            @(negedge iSysClk);
            soundRsp.sectorCke = 1'b0;
            if (soundReq.cke === 1'b1)
            begin
                soundBase = int'(soundReq.addr[lpColBits +: lpPageBits]) * lpSectorBytes;
                for (int j = 0; j < lpSectorBytes; j++)
                begin
                    @(negedge iSysClk);
                    soundRsp.rd   = soundImage[soundBase + j];
                    soundRsp.rdVd = 1'b1;
                    if (j % 3 == 2)
                    begin
                        @(negedge iSysClk);
                        soundRsp.rdVd = 1'b0;
                    end
                end
                @(negedge iSysClk);
                soundRsp.rdVd      = 1'b0;
                soundRsp.sectorCke = 1'b1;
            end
        end
    end

    // Request and slave write monitor
    initial
    begin
        forever
        begin
            @(negedge iSysClk);
            if (pixelReq.cke === 1'b1)
            begin
                pixAddrQ.push_back(pixelReq.addr);
                checkEq("pixelReq.cmd", 1, 32'(pixelReq.cmd));
            end
            if (soundReq.cke === 1'b1)
            begin
                soundAddrQ.push_back(soundReq.addr);
                checkEq("soundReq.cmd", 1, 32'(soundReq.cmd));
            end
            if (slaveWr.wdVd === 1'b1)
                slaveQ.push_back({slaveWr.addr, slaveWr.wd});
        end
    end

    // Sound generator model, logs samples and hands credits back
    initial
    begin
        iSgbCredit = '0;
        for (int ch = 0; ch < lpChannels; ch++)
        begin
            owed[ch]       = 0;
            manualDone[ch] = 0;
        end
        forever
        begin
            @(negedge iSysClk);
            for (int ch = 0; ch < lpChannels; ch++)
            begin
                iSgbCredit[ch] = 1'b0;
                if (sgbOut[ch].vd === 1'b1)
                begin
                    chanQ.push_back(ch);
                    valQ.push_back(sgbOut[ch].sample);
                    owed[ch]++;
                end
                if (owed[ch] > 0 && (autoCredit || manualReq[ch] != manualDone[ch]))
                begin
                    iSgbCredit[ch] = 1'b1;      // One-cycle credit pulse
                    owed[ch]--;
                    if (!autoCredit)
                        manualDone[ch]++;
                end
            end
        end
    end

    initial
    begin
        cycleCount = 0;
        while (cycleCount < lpTimeoutCycles)
        begin
            @(posedge iSysClk);
            cycleCount++;
        end
        $display("Timeout: run stopped after %0d cycles with tests still waiting", cycleCount);
        $display("Done: errors found");
        $finish;
    end

    // ------------------------------------------------
    // Helpers
    // ------------------------------------------------
    task automatic checkEq(input string testName, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        checkCount++;
        if (actVal !== expVal)
        begin
            errCount++;
            $display("FAILED %s: expected 0x%0h, actual 0x%0h", testName, expVal, actVal);
        end
    endtask

    task automatic waitCycles(input int n);
        repeat (n) @(posedge iSysClk);
    endtask

    // Sample i from bytes 2i and 2i+1, high byte first
    function automatic logic [lpSampleBits-1:0] expSample(input int i);
        return {soundImage[2*i], soundImage[2*i+1]};
    endfunction

    function automatic logic anyVd();
        logic v;
        v = 1'b0;
        for (int ch = 0; ch < lpChannels; ch++)
            v = v | sgbOut[ch].vd;
        return v;
    endfunction

    task automatic loadImages();
        seed = 52002;
        for (int i = 0; i < lpImageBytes; i++)
        begin
            pixImage[i]   = 8'(i) ^ 8'(i >> 8) ^ 8'h5A;   // Filler after the program
            soundImage[i] = 8'($random(seed));
        end
        for (int k = 0; k <= lpProgInstr; k++)
        begin
            for (int b = 0; b < 4; b++)
                pixImage[4*k + b] = lpProgram[k][31 - 8*b -: 8];
        end
    endtask

    // ------------------------------------------------
    // Directed tests
    // ------------------------------------------------
    task automatic resetTest();
        @(posedge iSysClk);
        for (int c = 0; c < 4; c++)
        begin
            @(negedge iSysClk);
            checkEq("reset.pixelCke", 0, 32'(pixelReq.cke));
            checkEq("reset.soundCke", 0, 32'(soundReq.cke));
            checkEq("reset.wdVd", 0, 32'(slaveWr.wdVd));
            checkEq("reset.chanVd", 0, 32'(anyVd()));
        end
        reset = 1'b0;
        @(negedge iSysClk);
        checkEq("afterReset.wdVd", 0, 32'(slaveWr.wdVd));
        checkEq("afterReset.chanVd", 0, 32'(anyVd()));
        while (pixAddrQ.size() == 0 || soundAddrQ.size() == 0)
            @(posedge iSysClk);
        checkEq("afterReset.pixelAddr", 0, 32'(pixAddrQ[0]));
        checkEq("afterReset.soundAddr", 0, 32'(soundAddrQ[0]));
    endtask

    task automatic pixelAddrTest();
        while (pixSectorsDone < 2)
            @(posedge iSysClk);
        waitCycles(200);                        // No cke after the end sector
        checkEq("pixelAddr.count", 2, pixAddrQ.size());
        for (int k = 0; k < pixAddrQ.size(); k++)
            checkEq($sformatf("pixelAddr[%0d]", k), 32'(k) * 32'(lpPageUp), 32'(pixAddrQ[k]));
    endtask

    task automatic slaveWriteTest();
        logic [31:0] expWr;
        checkEq("slaveWrite.count", lpProgInstr, slaveQ.size());
        for (int k = 0; k < lpProgInstr && k < slaveQ.size(); k++)
        begin
            expWr = {pixImage[4*k], pixImage[4*k+1], pixImage[4*k+2], pixImage[4*k+3]};
            checkEq($sformatf("slaveWrite[%0d]", k), expWr, slaveQ[k]);
        end
    endtask

    task automatic creditLimitTest();
        int perChan [lpChannels];
        for (int ch = 0; ch < lpChannels; ch++)
            perChan[ch] = 0;
        while (chanQ.size() < lpChannels * lpSoundCredits)
            @(posedge iSysClk);
        waitCycles(50);
        checkEq("creditLimit.count", lpChannels * lpSoundCredits, chanQ.size());
        for (int i = 0; i < chanQ.size(); i++)
        begin
            perChan[chanQ[i]]++;
            checkEq($sformatf("creditLimit.chan[%0d]", i), i % lpChannels, chanQ[i]);
            checkEq($sformatf("creditLimit.val[%0d]", i), 32'(expSample(i)), 32'(valQ[i]));
        end
        for (int ch = 0; ch < lpChannels; ch++)
            checkEq($sformatf("creditLimit.perChan[%0d]", ch), lpSoundCredits, perChan[ch]);
        manualReq[0]++;                         // One credit back on channel 0
        while (chanQ.size() <= lpChannels * lpSoundCredits)
            @(posedge iSysClk);
        waitCycles(20);                         // Nothing more without credit
        checkEq("creditLimit.afterReturn", lpChannels * lpSoundCredits + 1, chanQ.size());
        checkEq("creditLimit.extraChan", 0, chanQ[lpChannels * lpSoundCredits]);
        checkEq("creditLimit.extraVal", 32'(expSample(lpChannels * lpSoundCredits)),
                32'(valQ[lpChannels * lpSoundCredits]));
    endtask

    task automatic sampleRoutingTest();
        int base;
        int n;
        base       = chanQ.size();
        autoCredit = 1'b1;
        while (chanQ.size() < base + lpRouteSamples)
            @(posedge iSysClk);
        n = chanQ.size();
        for (int i = base; i < n; i++)
        begin
            checkEq($sformatf("sampleRouting.chan[%0d]", i), i % lpChannels, chanQ[i]);
            checkEq($sformatf("sampleRouting.val[%0d]", i), 32'(expSample(i)), 32'(valQ[i]));
        end
        // New sector only once the queue is empty
        checkEq("sampleRouting.sectors", (n + lpQueueDepth - 1) / lpQueueDepth,
                soundAddrQ.size());
        for (int k = 0; k < soundAddrQ.size(); k++)
            checkEq($sformatf("soundAddr[%0d]", k), 32'(k) * 32'(lpPageUp), 32'(soundAddrQ[k]));
    endtask

    initial
    begin
        reset      = 1'b1;
        autoCredit = 1'b0;
        errCount   = 0;
        checkCount = 0;
        for (int ch = 0; ch < lpChannels; ch++)
            manualReq[ch] = 0;
        loadImages();
        resetTest();
        pixelAddrTest();
        slaveWriteTest();
        creditLimitTest();
        sampleRoutingTest();
        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* build.f */
logic/cmbPkg.sv
logic/cmbControl.sv
logic/pixelCmdDecoder.sv
logic/soundSampleQueue.sv
logic/sgbDispatcher.sv
logic/cmbWrapper.sv
bench/cmbWrapperTb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wall
TOP       = cmbWrapperTb
FILELIST  = build.f
PASS_MSG  = Done: no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with $(VERILATOR), run $(TOP), look for the pass message"
	@echo "  clean  remove the obj_dir folder"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
